// File: src/outrun_io_pkg.sv
// Word accesses only, data in the low byte; group decode assumes the I/O window is already selected
`default_nettype none

package outrun_io_pkg;

    typedef logic [13:1] io_addr_t;    // Word address inside the I/O window
    typedef logic [15:0] bus_word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] motor_pos_t;
    typedef logic [2:0]  adc_ch_t;

    typedef struct packed {
        io_addr_t  addr;
        logic      we;
        bus_word_t wdata;
    } bus_req_t;

    typedef struct packed {
        bus_word_t rdata;
    } bus_rsp_t;

    // Cabinet side, joystick bits active low
    typedef struct packed {
        byte_t       joystick;
        logic [15:0] joyana_steer;
        logic [15:0] joyana_pedal;  // Gas in the upper half, brake below
        logic        start;
        logic [1:0]  coin;
        logic        service;
        logic        dip_test;
        byte_t       dipsw_a;
        byte_t       dipsw_b;
    } cab_in_t;

    typedef struct packed {
        byte_t port_a;
        byte_t port_b;
        byte_t port_c;
    } ppi_out_t;

    // Address bits 6 to 4
    typedef enum logic [2:0] {
        GRP_PPI   = 3'd0,
        GRP_INPUT = 3'd1,
        GRP_RSV2  = 3'd2,
        GRP_ADC   = 3'd3,
        GRP_RSV4  = 3'd4,
        GRP_RSV5  = 3'd5,
        GRP_WDOG  = 3'd6,       // Accepted, no effect
        GRP_OBJ   = 3'd7
    } grp_e;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        RESPOND
    } fsm_state_e;

    localparam byte_t      BYTE_NONE   = 8'hFF;  // Open bus byte
    localparam motor_pos_t MOTOR_MIN   = 16'h1000;
    localparam motor_pos_t MOTOR_MAX   = 16'hF000;
    localparam motor_pos_t MOTOR_RESET = 16'h8000;

endpackage

`default_nettype wire

// File: src/bus_cycle_fsm.sv
// One request per three cycles; a request strobe outside IDLE is dropped, no back-pressure
`default_nettype none

module bus_cycle_fsm
    import outrun_io_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     req_valid,
    input  wire bus_req_t req,
    input  wire byte_t    ppi_rdata,
    input  wire byte_t    cab_rdata,
    output logic [1:0]    reg_sel,
    output byte_t         wdata,
    output logic          grp_adc,
    output logic          ppi_wr,
    output logic          adc_wr,
    output logic          obj_toggle,
    output logic          ack,
    output bus_rsp_t      rsp
);

    fsm_state_e state;
    bus_req_t   req_q;
    grp_e       grp;
    logic       access;
    byte_t      rd_byte;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (req_valid) state <= ACCESS;
                ACCESS:  state <= RESPOND;
                default: state <= IDLE;    // RESPOND lasts one cycle
            endcase
        end
    end

    // Request and read data payload
    always_ff @(posedge clk) begin
        if (state == IDLE && req_valid) begin
            req_q <= req;
        end
        if (access) begin
            rsp.rdata <= {BYTE_NONE, rd_byte};
        end
    end

    assign grp     = grp_e'(req_q.addr[6:4]);
    assign access  = (state == ACCESS);
    assign reg_sel = req_q.addr[2:1];
    assign wdata   = req_q.wdata[7:0];
    assign grp_adc = (grp == GRP_ADC);
    assign ack     = (state == RESPOND);

    // Only one strobe can be high, groups are exclusive
    assign ppi_wr     = access && req_q.we && (grp == GRP_PPI);
    assign adc_wr     = access && req_q.we && (grp == GRP_ADC);
    assign obj_toggle = access && (grp == GRP_OBJ);

    always_comb begin
        case (grp)
            GRP_PPI:            rd_byte = ppi_rdata;
            GRP_INPUT, GRP_ADC: rd_byte = cab_rdata;
            default:            rd_byte = BYTE_NONE;  // Watchdog, object and spare groups
        endcase
    end

endmodule

`default_nettype wire

// File: src/ppi_ports.sv
// Mode 0 only, port A input only; the mode byte is stored for read-back and does not change port direction
`default_nettype none

module ppi_ports
    import outrun_io_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic [1:0] reg_sel,
    input  wire byte_t      wdata,
    input  wire logic       wr,
    input  wire logic [2:0] motor_lim,
    output byte_t           rdata,
    output ppi_out_t        ports
);

    byte_t pa_pins;
    byte_t port_b;
    byte_t port_c;
    byte_t mode;

    assign pa_pins = {2'b00, motor_lim, 3'b111};  // Limit switches on port A pins

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            port_b <= '0;
            port_c <= '0;   // Sound held in reset, video off
            mode   <= '0;
        end else if (wr) begin
            case (reg_sel)
                2'd1: port_b <= wdata;
                2'd2: port_c <= wdata;
                2'd3: begin
                    if (wdata[7]) begin
                        mode <= wdata;
                    end else begin
                        port_c[wdata[3:1]] <= wdata[0];  // Bit set/reset
                    end
                end
                default: ;  // Port A has no output latch
            endcase
        end
    end

    always_comb begin
        case (reg_sel)
            2'd0: rdata = pa_pins;
            2'd1: rdata = port_b;
            2'd2: rdata = port_c;
            default: rdata = mode;
        endcase
    end

    assign ports = '{port_a: pa_pins, port_b: port_b, port_c: port_c};

endmodule

`default_nettype wire

// File: src/cab_inputs.sv
// Joystick overrides read live bits, the analog values only update on an ADC write
`default_nettype none

module cab_inputs
    import outrun_io_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire cab_in_t    cab,
    input  wire logic [1:0] reg_sel,
    input  wire logic       adc_wr,
    input  wire adc_ch_t    adc_ch,
    input  wire motor_pos_t motor_pos,
    input  wire logic       grp_adc,
    output byte_t           rdata
);

    logic [15:0] steer_q;
    logic [15:0] pedal_q;
    byte_t       in_byte;
    byte_t       adc_byte;
    byte_t       pedal_hi;

    // Analog latch
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            steer_q <= '0;
            pedal_q <= '0;
        end else if (adc_wr) begin
            steer_q <= cab.joyana_steer;
            pedal_q <= cab.joyana_pedal;
        end
    end

    // Bit 14 fills the LSB
    assign pedal_hi = {pedal_q[14:8], pedal_q[14]};

    always_comb begin
        case (reg_sel)
            2'd0: in_byte = {cab.coin, ~cab.joystick[4], cab.joystick[4],
                             cab.start, cab.service, cab.dip_test, 1'b1};
            2'd1: in_byte = BYTE_NONE;
            2'd2: in_byte = cab.dipsw_a;
            default: in_byte = cab.dipsw_b;
        endcase
    end

    always_comb begin
        case (adc_ch)
            3'd0: begin    // Steering, left and right buttons override
                if (!cab.joystick[0]) begin
                    adc_byte = 8'hD0;
                end else if (!cab.joystick[1]) begin
                    adc_byte = 8'h20;
                end else begin
                    adc_byte = steer_q[7:0] ^ 8'h80;
                end
            end
            3'd1: begin    // Gas
                if (!cab.joystick[3]) begin
                    adc_byte = 8'hF0;
                end else begin
                    adc_byte = pedal_q[15] ? ~pedal_hi : 8'h00;
                end
            end
            3'd2: begin    // Brake
                if (!cab.joystick[2]) begin
                    adc_byte = 8'hF0;
                end else begin
                    adc_byte = pedal_q[15] ? 8'h00 : pedal_hi;
                end
            end
            3'd3: adc_byte = motor_pos[15:8];  // Seat position
            default: adc_byte = BYTE_NONE;
        endcase
    end

    assign rdata = grp_adc ? adc_byte : in_byte;

endmodule

`default_nettype wire

// File: src/motor_model.sv
// Idealized seat motor: fixed step per frame, no inertia; ctrl 2'b11 holds like 2'b00
`default_nettype none

module motor_model
    import outrun_io_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  vint,
    input  wire byte_t ctrl,
    output motor_pos_t pos,
    output logic [2:0] lim
);

    motor_pos_t  step;
    logic [16:0] pos_up;
    logic [16:0] pos_dn;

    // 256 x (speed + 1)
    assign step   = {3'b000, {1'b0, ctrl[7:4]} + 5'd1, 8'h00};
    assign pos_up = {1'b0, pos} + {1'b0, step};
    assign pos_dn = {1'b0, pos} - {1'b0, step};  // Bit 16 set on underflow

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos <= MOTOR_RESET;
        end else if (vint) begin
            case (ctrl[1:0])
                2'b01: begin
                    pos <= (pos_up > {1'b0, MOTOR_MAX}) ? MOTOR_MAX : pos_up[15:0];
                end
                2'b10: begin
                    if (pos_dn[16] || pos_dn[15:0] < MOTOR_MIN) begin
                        pos <= MOTOR_MIN;
                    end else begin
                        pos <= pos_dn[15:0];
                    end
                end
                default: pos <= pos;
            endcase
        end
    end

    assign lim[2] = (pos == MOTOR_MAX);
    assign lim[1] = (pos[15:8] == 8'h80);  // Centre switch
    assign lim[0] = (pos == MOTOR_MIN);

endmodule

`default_nettype wire

// File: src/outrun_io_top.sv
// Host must wait for ack before the next request; vint is a single-cycle pulse
`default_nettype none

module outrun_io_top
    import outrun_io_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     req_valid,
    input  wire bus_req_t req,
    input  wire logic     vint,
    input  wire cab_in_t  cab,
    output logic          ack,
    output bus_rsp_t      rsp,
    output logic [1:0]    obj_cfg,
    output logic          video_en,
    output adc_ch_t       adc_ch,
    output logic          snd_rstb,
    output logic          obj_toggle
);

    logic [1:0] reg_sel;
    byte_t      wdata;
    logic       grp_adc;
    logic       ppi_wr;
    logic       adc_wr;
    byte_t      ppi_rdata;
    byte_t      cab_rdata;
    ppi_out_t   ppi_out;
    motor_pos_t motor_pos;
    logic [2:0] motor_lim;

    bus_cycle_fsm u_fsm (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .ppi_rdata  (ppi_rdata),
        .cab_rdata  (cab_rdata),
        .reg_sel    (reg_sel),
        .wdata      (wdata),
        .grp_adc    (grp_adc),
        .ppi_wr     (ppi_wr),
        .adc_wr     (adc_wr),
        .obj_toggle (obj_toggle),
        .ack        (ack),
        .rsp        (rsp)
    );

    ppi_ports u_ppi (
        .clk       (clk),
        .rst       (rst),
        .reg_sel   (reg_sel),
        .wdata     (wdata),
        .wr        (ppi_wr),
        .motor_lim (motor_lim),
        .rdata     (ppi_rdata),
        .ports     (ppi_out)
    );

    cab_inputs u_cab (
        .clk       (clk),
        .rst       (rst),
        .cab       (cab),
        .reg_sel   (reg_sel),
        .adc_wr    (adc_wr),
        .adc_ch    (adc_ch),
        .motor_pos (motor_pos),
        .grp_adc   (grp_adc),
        .rdata     (cab_rdata)
    );

    motor_model u_motor (
        .clk  (clk),
        .rst  (rst),
        .vint (vint),
        .ctrl (ppi_out.port_b),   // Seat drive
        .pos  (motor_pos),
        .lim  (motor_lim)
    );

    // Port C fan-out
    assign obj_cfg  = ppi_out.port_c[7:6];
    assign video_en = ppi_out.port_c[5];
    assign adc_ch   = ppi_out.port_c[4:2];
    assign snd_rstb = ppi_out.port_c[0];

endmodule

`default_nettype wire

// File: tb/io_checker.sv
// Samples on the falling clock edge; one request in flight at a time, as the host promises
`default_nettype none

module io_checker
    import outrun_io_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     req_valid,
    input  wire bus_req_t req,
    input  wire logic     ack,
    input  wire bus_rsp_t rsp,
    input  wire logic     obj_toggle,
    input  wire logic [1:0] obj_cfg,
    input  wire logic     video_en,
    input  wire adc_ch_t  adc_ch,
    input  wire logic     snd_rstb
);

    int        err_val;
    int        err_proto;
    int        n_req;
    int        n_ack;
    int        n_obj_req;
    int        n_obj_pulse;
    int        n_exp;       // Reads announced by the stimulus side
    int        n_chk;       // Reads compared here
    int        wait_cyc;
    logic      busy = 1'b0;
    string     exp_name;
    bus_word_t exp_word;
    bus_req_t  req_q;
    logic [6:0] pins;

    task automatic expect_read(input string name, input bus_word_t word);
        exp_name = name;
        exp_word = word;
        n_exp++;
    endtask

    assign pins = {obj_cfg, video_en, adc_ch, snd_rstb};

    task automatic check_response();
        if (n_exp != n_chk) begin
            n_chk = n_exp;
            if (rsp.rdata !== exp_word) begin
                $display("ERR %s: expected %h, got %h", exp_name, exp_word, rsp.rdata);
                err_val++;
            end
            // Port C pins carry all bits but bit 1
            if (req_q.addr[6:4] == GRP_PPI && req_q.addr[2:1] == 2'd2
                    && pins !== {exp_word[7:2], exp_word[0]}) begin
                $display("ERR %s port C pins: expected %h, got %h", exp_name,
                         {exp_word[7:2], exp_word[0]}, pins);
                err_val++;
            end
        end
        if (req_q.addr[6:4] == GRP_OBJ && n_obj_pulse != n_obj_req) begin
            $display("ERR obj_toggle: expected %0d pulses, got %0d", n_obj_req, n_obj_pulse);
            err_val++;
        end
    endtask

    always @(negedge clk) begin
        if (rst) begin
            if ({pins, ack, obj_toggle} !== 9'h000) begin
                $display("ERR reset_outputs: expected %h, got %h", 9'h000, {pins, ack, obj_toggle});
                err_val++;
            end
        end else begin
            if (req_valid) begin
                n_req++;
                req_q = req;
                busy = 1'b1;
                wait_cyc = 0;
                if (req.addr[6:4] == GRP_OBJ) n_obj_req++;
            end else if (busy && !ack) begin
                wait_cyc++;
                if (wait_cyc > 4) begin
                    $display("Request to address %h got no acknowledge within 4 cycles",
                             req_q.addr);
                    err_proto++;
                    busy = 1'b0;
                end
            end
            if (obj_toggle) n_obj_pulse++;
            if (ack) begin
                n_ack++;
                busy = 1'b0;
                check_response();
            end
        end
    end

    // End of run totals
    function automatic int count_mismatches();
        int bad;
        bad = 0;
        if (n_ack != n_req) begin
            $display("Saw %0d acknowledges for %0d requests", n_ack, n_req);
            bad++;
        end
        if (n_obj_pulse != n_obj_req) begin
            $display("Saw %0d obj_toggle pulses for %0d object accesses", n_obj_pulse, n_obj_req);
            bad++;
        end
        return bad;
    endfunction

endmodule

`default_nettype wire

// File: tb/tb_top.sv
// Cabinet inputs change only at step boundaries; ADC write data bit 0 picks the sign of the pedal
`default_nettype none

module tb_top
    import outrun_io_pkg::*;
();

    typedef enum logic [1:0] {K_READ, K_WRITE, K_VINT} step_kind_e;

    typedef struct packed {
        step_kind_e kind;
        io_addr_t   addr;
        byte_t      wval;
        byte_t      exp;
        logic [7:0] nv;      // Frames in a vint burst
    } step_t;

    logic       clk = 1'b0;
    logic       rst;
    logic       req_valid;
    bus_req_t   req;
    logic       vint;
    cab_in_t    cab;
    logic       ack;
    bus_rsp_t   rsp;
    logic [1:0] obj_cfg;
    logic       video_en;
    adc_ch_t    adc_ch;
    logic       snd_rstb;
    logic       obj_toggle;

    step_t       steps[64];
    string       names[64];
    cab_in_t     cabs[64];
    int          n = 0;
    int          cycles = 0;
    int          limit;
    int          proto;
    logic [31:0] seed = 32'h23b73e13;
    cab_in_t     cur_cab;
    logic [3:0]  joy_lo = 4'hF;     // Direction buttons, active low
    byte_t       pc = 8'h00;        // Port C as the host has written it
    logic [15:0] lat_steer = '0;
    logic [15:0] lat_pedal = '0;

    always #4 clk = ~clk;

    outrun_io_top dut0 (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req(req), .vint(vint), .cab(cab),
        .ack(ack), .rsp(rsp), .obj_cfg(obj_cfg), .video_en(video_en), .adc_ch(adc_ch),
        .snd_rstb(snd_rstb), .obj_toggle(obj_toggle)
    );

    io_checker chk0 (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req(req), .ack(ack), .rsp(rsp),
        .obj_toggle(obj_toggle), .obj_cfg(obj_cfg), .video_en(video_en), .adc_ch(adc_ch),
        .snd_rstb(snd_rstb)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic io_addr_t make_addr(input grp_e g, input logic [1:0] r);
        io_addr_t a;
        a = '0;
        a[6:4] = g;
        a[2:1] = r;
        return a;
    endfunction

    function automatic byte_t input_rule(input logic [1:0] r, input cab_in_t c);
        case (r)
            2'd0: return {c.coin, ~c.joystick[4], c.joystick[4],
                          c.start, c.service, c.dip_test, 1'b1};
            2'd1: return 8'hFF;
            2'd2: return c.dipsw_a;
            default: return c.dipsw_b;
        endcase
    endfunction

    function automatic byte_t adc_rule(input adc_ch_t ch, input cab_in_t c);
        byte_t half;
        half = {lat_pedal[14:8], lat_pedal[14]};
        if (ch == 3'd0) begin
            return !c.joystick[0] ? 8'hD0 : (!c.joystick[1] ? 8'h20 : lat_steer[7:0] ^ 8'h80);
        end
        if (ch == 3'd1) return !c.joystick[3] ? 8'hF0 : (lat_pedal[15] ? ~half : 8'h00);
        return !c.joystick[2] ? 8'hF0 : (lat_pedal[15] ? 8'h00 : half);
    endfunction

    task automatic roll_cab();
        logic [31:0] hi;
        logic [63:0] w;
        seed = xorshift(seed);
        hi = seed;
        seed = xorshift(seed);
        w = {hi, seed};
        cur_cab = w[60:0];
        cur_cab.joystick[3:0] = joy_lo;
    endtask

    // Appends a step; input and ADC channel 0..2 expectations come from the read rules
    task automatic add_step(input string nm, input step_kind_e k, input grp_e g,
                            input logic [1:0] r, input byte_t wv, input byte_t ex,
                            input logic [7:0] nv);
        roll_cab();
        if (k == K_WRITE && g == GRP_ADC) begin
            cur_cab.joyana_pedal[15] = wv[0];
            lat_steer = cur_cab.joyana_steer;
            lat_pedal = cur_cab.joyana_pedal;
        end
        if (k == K_WRITE && g == GRP_PPI && r == 2'd2) pc = wv;
        if (k == K_WRITE && g == GRP_PPI && r == 2'd3 && !wv[7]) pc[wv[3:1]] = wv[0];
        if (g == GRP_INPUT) ex = input_rule(r, cur_cab);
        else if (g == GRP_ADC && pc[4:2] < 3'd3) ex = adc_rule(pc[4:2], cur_cab);
        names[n] = nm;
        cabs[n] = cur_cab;
        steps[n] = '{kind: k, addr: make_addr(g, r), wval: wv, exp: ex, nv: nv};
        n++;
    endtask

    task automatic build_table();
        add_step("pc_reset",      K_READ,  GRP_PPI,   2'd2, 8'h00, 8'h00, 8'd0);
        add_step("pa_reset",      K_READ,  GRP_PPI,   2'd0, 8'h00, 8'h17, 8'd0);
        add_step("adc0_reset",    K_READ,  GRP_ADC,   2'd0, 8'h00, 8'h00, 8'd0);
        add_step("sel_ch3_rst",   K_WRITE, GRP_PPI,   2'd2, 8'h0C, 8'h00, 8'd0);
        add_step("ch3_reset",     K_READ,  GRP_ADC,   2'd0, 8'h00, 8'h80, 8'd0);
        add_step("in_sw",         K_READ,  GRP_INPUT, 2'd0, 8'h00, 8'h00, 8'd0);
        add_step("in_none",       K_READ,  GRP_INPUT, 2'd1, 8'h00, 8'h00, 8'd0);
        add_step("in_dip_a",      K_READ,  GRP_INPUT, 2'd2, 8'h00, 8'h00, 8'd0);
        add_step("in_dip_b",      K_READ,  GRP_INPUT, 2'd3, 8'h00, 8'h00, 8'd0);
        add_step("pb_wr",         K_WRITE, GRP_PPI,   2'd1, 8'h5A, 8'h00, 8'd0);
        add_step("pb_rd",         K_READ,  GRP_PPI,   2'd1, 8'h00, 8'h5A, 8'd0);
        add_step("pc_wr",         K_WRITE, GRP_PPI,   2'd2, 8'hE5, 8'h00, 8'd0);
        add_step("pc_rd",         K_READ,  GRP_PPI,   2'd2, 8'h00, 8'hE5, 8'd0);
        add_step("bsr_clr5",      K_WRITE, GRP_PPI,   2'd3, 8'h0A, 8'h00, 8'd0);
        add_step("bsr_clr5_rd",   K_READ,  GRP_PPI,   2'd2, 8'h00, 8'hC5, 8'd0);
        add_step("mode_wr",       K_WRITE, GRP_PPI,   2'd3, 8'h9B, 8'h00, 8'd0);
        add_step("mode_rd",       K_READ,  GRP_PPI,   2'd3, 8'h00, 8'h9B, 8'd0);
        add_step("pc_keep_rd",    K_READ,  GRP_PPI,   2'd2, 8'h00, 8'hC5, 8'd0);
        add_step("sel_ch0",       K_WRITE, GRP_PPI,   2'd2, 8'h21, 8'h00, 8'd0);
        add_step("latch_neg",     K_WRITE, GRP_ADC,   2'd0, 8'h01, 8'h00, 8'd0);
        add_step("ch0_steer",     K_READ,  GRP_ADC,   2'd0, 8'h00, 8'h00, 8'd0);
        joy_lo = 4'hE;
        add_step("ch0_left",      K_READ,  GRP_ADC,   2'd0, 8'h00, 8'h00, 8'd0);
        joy_lo = 4'hD;
        add_step("ch0_right",     K_READ,  GRP_ADC,   2'd0, 8'h00, 8'h00, 8'd0);
        joy_lo = 4'hF;
        add_step("sel_ch1",       K_WRITE, GRP_PPI,   2'd2, 8'h25, 8'h00, 8'd0);
        add_step("ch1_gas",       K_READ,  GRP_ADC,   2'd0, 8'h00, 8'h00, 8'd0);
        joy_lo = 4'h7;
        add_step("ch1_gas_btn",   K_READ,  GRP_ADC,   2'd0, 8'h00, 8'h00, 8'd0);
        joy_lo = 4'hF;
        add_step("sel_ch2",       K_WRITE, GRP_PPI,   2'd2, 8'h29, 8'h00, 8'd0);
        add_step("ch2_brake",     K_READ,  GRP_ADC,   2'd0, 8'h00, 8'h00, 8'd0);
        joy_lo = 4'hB;
        add_step("ch2_brake_btn", K_READ,  GRP_ADC,   2'd0, 8'h00, 8'h00, 8'd0);
        joy_lo = 4'hF;
        add_step("latch_pos",     K_WRITE, GRP_ADC,   2'd0, 8'h00, 8'h00, 8'd0);
        add_step("ch2_brake_pos", K_READ,  GRP_ADC,   2'd0, 8'h00, 8'h00, 8'd0);
        add_step("sel_ch1_again", K_WRITE, GRP_PPI,   2'd2, 8'h25, 8'h00, 8'd0);
        add_step("ch1_gas_pos",   K_READ,  GRP_ADC,   2'd0, 8'h00, 8'h00, 8'd0);
        add_step("sel_ch3",       K_WRITE, GRP_PPI,   2'd2, 8'h2D, 8'h00, 8'd0);
        add_step("motor_up",      K_WRITE, GRP_PPI,   2'd1, 8'h31, 8'h00, 8'd0);
        add_step("vint_2",        K_VINT,  GRP_PPI,   2'd0, 8'h00, 8'h00, 8'd2);
        add_step("motor_8800",    K_READ,  GRP_ADC,   2'd0, 8'h00, 8'h88, 8'd0);
        add_step("vint_40",       K_VINT,  GRP_PPI,   2'd0, 8'h00, 8'h00, 8'd40);
        add_step("motor_max",     K_READ,  GRP_ADC,   2'd0, 8'h00, 8'hF0, 8'd0);
        add_step("pa_max",        K_READ,  GRP_PPI,   2'd0, 8'h00, 8'h27, 8'd0);
        add_step("motor_down",    K_WRITE, GRP_PPI,   2'd1, 8'hF2, 8'h00, 8'd0);
        add_step("vint_7",        K_VINT,  GRP_PPI,   2'd0, 8'h00, 8'h00, 8'd7);
        add_step("pa_centre",     K_READ,  GRP_PPI,   2'd0, 8'h00, 8'h17, 8'd0);
        add_step("vint_20",       K_VINT,  GRP_PPI,   2'd0, 8'h00, 8'h00, 8'd20);
        add_step("motor_min",     K_READ,  GRP_ADC,   2'd0, 8'h00, 8'h10, 8'd0);
        add_step("pa_min",        K_READ,  GRP_PPI,   2'd0, 8'h00, 8'h0F, 8'd0);
        add_step("obj_rd",        K_READ,  GRP_OBJ,   2'd0, 8'h00, 8'hFF, 8'd0);
        add_step("obj_wr",        K_WRITE, GRP_OBJ,   2'd0, 8'h55, 8'h00, 8'd0);
        add_step("wdog_wr",       K_WRITE, GRP_WDOG,  2'd0, 8'hAA, 8'h00, 8'd0);
        add_step("spare_rd",      K_READ,  GRP_RSV5,  2'd3, 8'h00, 8'hFF, 8'd0);
    endtask

    // Starts a posedge plus one unit after the previous step
    task automatic run_step(input int i);
        cab = cabs[i];
        if (steps[i].kind == K_VINT) begin
            repeat (steps[i].nv) begin
                vint = 1'b1;
                @(posedge clk);
                #1 vint = 1'b0;
                @(posedge clk);
                #1;
            end
        end else begin
            req.addr = steps[i].addr;
            req.we = (steps[i].kind == K_WRITE);
            req.wdata = {8'h00, steps[i].wval};
            if (steps[i].kind == K_READ) chk0.expect_read(names[i], {8'hFF, steps[i].exp});
            req_valid = 1'b1;
            @(posedge clk);
            #1 req_valid = 1'b0;
            while (!ack) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: run did not finish within %0d cycles", limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        req_valid = 1'b0;
        req = '0;
        vint = 1'b0;
        cab = '0;
        build_table();
        limit = 20 * n + 200;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #1;
            run_step(i);
        end
        repeat (4) @(posedge clk);
        proto = chk0.err_proto + chk0.count_mismatches();
        $display("Errors: %0d value, %0d protocol", chk0.err_val, proto);
        if (chk0.err_val == 0 && proto == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
src/outrun_io_pkg.sv
src/bus_cycle_fsm.sv
src/ppi_ports.sv
src/cab_inputs.sv
src/motor_model.sv
src/outrun_io_top.sv
tb/io_checker.sv
tb/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_top -f sources.f || exit 1
out="$(./obj_dir/Vtb_top)"
echo "$out"
grep -qx "Simulation finished: PASS" <<< "$out" && echo "run.sh: passed" \
    || { echo "run.sh: failed"; exit 1; }
